// ==== verilog/boot_macros.svh ====
`ifndef BOOT_MACROS_SVH
`define BOOT_MACROS_SVH

//////////////////////////////
// Reset hold
//////////////////////////////

// Clear cycles needed after the last reset source goes away
`define BOOT_HOLD_CYCLES 32

// Hold counter width, wide enough to reach the hold length itself
`define BOOT_HOLD_BITS 6

//////////////////////////////
// Fetch
//////////////////////////////

// First fetch address, driven onto the IBUS while held
`define BOOT_RESET_VECTOR 16'hfff0

// Addresses and instruction words share one width
`define BOOT_WORD_BITS 16

// An instruction word splits into an opcode and a page operand
`define BOOT_OPCODE_BITS 4
`define BOOT_PAGE_BITS 12

`endif

// ==== verilog/boot_pkg.sv ====
`include "boot_macros.svh"

package boot_pkg;

   //////////////////////////////
   // Instruction words
   //////////////////////////////

   // Opcodes known to the boot sequencer
   // Every other value is treated the same as NOP
   typedef enum logic [`BOOT_OPCODE_BITS-1:0] {
      NOP  = 4'd0,
      JMP  = 4'd1,
      JMPL = 4'd2,
      HALT = 4'd3
   } opcode_e;

   // Instruction view of a fetched word, opcode in the top nibble
   typedef struct packed {
      opcode_e                      opcode;
      logic [`BOOT_PAGE_BITS-1:0]   operand;
   } instr_s;

   // A fetched word is either an instruction or the address word after a JMPL
   typedef union packed {
      instr_s                       instr;
      logic [`BOOT_WORD_BITS-1:0]   addr;
   } ibus_word_u;

   //////////////////////////////
   // Sequencer to PC
   //////////////////////////////

   // What the PC loads at the next clock edge
   typedef enum logic [1:0] {
      HOLD      = 2'd0,
      INC       = 2'd1,
      JUMP_PAGE = 2'd2,
      JUMP_LONG = 2'd3
   } pc_cmd_e;

   //////////////////////////////
   // Memory port
   //////////////////////////////

   // Read request, strobe is high for a single cycle
   typedef struct packed {
      logic                         strobe;
      logic [`BOOT_WORD_BITS-1:0]   addr;
   } mem_req_s;

   // Read response, valid exactly one cycle after the strobe
   typedef struct packed {
      logic                         valid;
      ibus_word_u                   data;
   } mem_rsp_s;

endpackage

// ==== verilog/reset_hold_timer.sv ====
`timescale 1ns/100ps

`include "boot_macros.svh"

module reset_hold_timer (
   input  logic clk,
   input  logic reset,
   input  logic fp_reset,
   input  logic power_ok,
   output logic rst_hold
);

   //////////////////////////////
   // Reset sources
   //////////////////////////////

   // All three sources are wired together into a single demand
   // A low power_ok counts as a reset request just like the two buttons
   logic reset_demand;

   assign reset_demand = reset | fp_reset | ~power_ok;

   //////////////////////////////
   // Hold counter
   //////////////////////////////

   // Counts clear cycles since the demand last went away
   // It stops once it reaches the hold length and rst_hold drops
   logic [`BOOT_HOLD_BITS-1:0] hold_count;

   // Registered hold flag that any demand sets and the end of the count clears
   logic                       hold_q;

   always_ff @(posedge clk) begin
      if (reset_demand) begin
         // Any source restarts the count even halfway through a hold
         hold_count <= '0;
         hold_q     <= 1'b1;
      end else if (hold_q) begin
         hold_count <= hold_count + 1'b1;
         // On the last count of the hold rst_hold drops after this edge
         if (hold_count == `BOOT_HOLD_BITS'(`BOOT_HOLD_CYCLES - 1)) begin
            hold_q <= 1'b0;
         end
      end
   end

   // The counter is left sitting at the hold length once released
   assign rst_hold = hold_q;

   //////////////////////////////
   // Checks
   //////////////////////////////

   // A source seen at one edge keeps rst_hold up for the whole hold period
   // that follows, and the first of those cycles is the next one
   a_hold_after_demand : assert property (
      @(posedge clk) reset_demand |=> rst_hold [*`BOOT_HOLD_CYCLES]
   );

   // A demand followed by a full run of clear cycles lets rst_hold fall right away
   a_release_after_clear : assert property (
      @(posedge clk) reset_demand ##1 (!reset_demand) [*`BOOT_HOLD_CYCLES] |=> !rst_hold
   );

endmodule

// ==== verilog/program_counter.sv ====
`timescale 1ns/100ps

`include "boot_macros.svh"

module program_counter (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         rst_hold,
   input  boot_pkg::pc_cmd_e            pc_cmd,
   input  boot_pkg::ibus_word_u         operand,
   output logic [`BOOT_WORD_BITS-1:0]   pc
);

   //////////////////////////////
   // IBUS source selection
   //////////////////////////////

   // The IBUS carries the next PC value, one source at a time
   logic [`BOOT_WORD_BITS-1:0] ibus;

   // Page of the current PC that an in-page jump keeps
   logic [`BOOT_WORD_BITS-`BOOT_PAGE_BITS-1:0] cur_page;

   assign cur_page = pc[`BOOT_WORD_BITS-1:`BOOT_PAGE_BITS];

   always_comb begin
      if (rst_hold) begin
         // The reset vector wins over any command while the hold lasts
         ibus = `BOOT_RESET_VECTOR;
      end else begin
         case (pc_cmd)
            boot_pkg::INC: begin
               ibus = pc + 1'b1;
            end
            boot_pkg::JUMP_PAGE: begin
               // The top nibble stays and the low twelve bits come from the JMP word
               ibus = {cur_page, operand.instr.operand};
            end
            boot_pkg::JUMP_LONG: begin
               // The whole word is the target address here
               ibus = operand.addr;
            end
            default: begin
               // hold the current address
               ibus = pc;
            end
         endcase
      end
   end

   //////////////////////////////
   // PC register
   //////////////////////////////

   // Loads the IBUS value each clock, so a command takes effect one cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `BOOT_RESET_VECTOR;
      end else begin
         pc <= ibus;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Whatever the sequencer was commanding, a held cycle leaves pc at the vector
   a_vector_on_hold : assert property (
      @(posedge clk) rst_hold |=> (pc == `BOOT_RESET_VECTOR)
   );

endmodule

// ==== verilog/fetch_sequencer.sv ====
`timescale 1ns/100ps

`include "boot_macros.svh"

module fetch_sequencer (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         rst_hold,
   input  logic [`BOOT_WORD_BITS-1:0]   pc,
   output boot_pkg::mem_req_s           mem_req,
   input  boot_pkg::mem_rsp_s           mem_rsp,
   output boot_pkg::pc_cmd_e            pc_cmd,
   output boot_pkg::ibus_word_u         operand,
   output logic                         halted
);

   //////////////////////////////
   // State machine
   //////////////////////////////

   // IDLE doubles as the first fetch once the hold is gone
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      WAIT,
      LONG_FETCH,
      LONG_WAIT,
      HALT
   } state_e;

   state_e state;
   state_e state_next;

   // Strobe wanted by the current state, before the hold mask
   logic   fetch_cycle;

   always_comb begin
      state_next  = state;
      pc_cmd      = boot_pkg::HOLD;
      fetch_cycle = 1'b0;
      case (state)
         IDLE, FETCH: begin
            // Read the word at the current PC
            fetch_cycle = 1'b1;
            state_next  = WAIT;
         end
         WAIT: begin
            // Decode the instruction view of the returned word
            if (mem_rsp.valid) begin
               case (mem_rsp.data.instr.opcode)
                  boot_pkg::JMP: begin
                     pc_cmd     = boot_pkg::JUMP_PAGE;
                     state_next = FETCH;
                  end
                  boot_pkg::JMPL: begin
                     // Step onto the address word and read it next
                     pc_cmd     = boot_pkg::INC;
                     state_next = LONG_FETCH;
                  end
                  boot_pkg::HALT: begin
                     state_next = HALT;
                  end
                  default: begin
                     // NOP and every unknown opcode just move on
                     pc_cmd     = boot_pkg::INC;
                     state_next = FETCH;
                  end
               endcase
            end
         end
         LONG_FETCH: begin
            fetch_cycle = 1'b1;
            state_next  = LONG_WAIT;
         end
         LONG_WAIT: begin
            // This word is a full address, not an instruction
            if (mem_rsp.valid) begin
               pc_cmd     = boot_pkg::JUMP_LONG;
               state_next = FETCH;
            end
         end
         default: begin
            // HALT waits here until the hold comes back
            state_next = HALT;
         end
      endcase
   end

   // The hold pulls everything back to IDLE, including a halted machine
   always_ff @(posedge clk) begin
      if (reset || rst_hold) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   //////////////////////////////
   // Outputs
   //////////////////////////////

   // No strobe goes out while held, even from a fetch state left over
   // from before the hold rose
   assign mem_req.strobe = fetch_cycle & ~rst_hold;
   assign mem_req.addr   = pc;

   // The PC takes its jump operand straight from the returned word
   assign operand = mem_rsp.data;
   assign halted  = (state == HALT);

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Memory answers one cycle after a strobe and never on its own
   a_rsp_after_strobe : assert property (
      @(posedge clk) disable iff (reset)
         mem_rsp.valid |-> $past(mem_req.strobe)
   );

   // Once halted, the bus stays quiet until the next hold
   a_quiet_after_halt : assert property (
      @(posedge clk) disable iff (reset)
         $rose(halted) |-> (!mem_req.strobe throughout rst_hold [->1])
   );

endmodule

// ==== verilog/boot_top.sv ====
`timescale 1ns/100ps

`include "boot_macros.svh"

module boot_top (
   input  logic                clk,
   input  logic                reset,
   input  logic                fp_reset,
   input  logic                power_ok,
   output boot_pkg::mem_req_s  mem_req,
   input  boot_pkg::mem_rsp_s  mem_rsp,
   output logic                rst_hold,
   output logic                halted
);

   //////////////////////////////
   // Internal wiring
   //////////////////////////////

   // Command and jump operand from the sequencer to the PC
   boot_pkg::pc_cmd_e            pc_cmd;
   boot_pkg::ibus_word_u         operand;

   // Current fetch address back to the sequencer
   logic [`BOOT_WORD_BITS-1:0]   pc;

   //////////////////////////////
   // Blocks
   //////////////////////////////

   // Stretches the release of any reset source into the hold period
   reset_hold_timer u_reset_hold_timer (
      .clk      (clk),
      .reset    (reset),
      .fp_reset (fp_reset),
      .power_ok (power_ok),
      .rst_hold (rst_hold)
   );

   // Holds the reset vector during the hold, then follows the sequencer
   program_counter u_program_counter (
      .clk      (clk),
      .reset    (reset),
      .rst_hold (rst_hold),
      .pc_cmd   (pc_cmd),
      .operand  (operand),
      .pc       (pc)
   );

   // Reads and decodes instruction words once the hold is over
   fetch_sequencer u_fetch_sequencer (
      .clk      (clk),
      .reset    (reset),
      .rst_hold (rst_hold),
      .pc       (pc),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp),
      .pc_cmd   (pc_cmd),
      .operand  (operand),
      .halted   (halted)
   );

endmodule

// ==== dv/boot_tb.sv ====
`timescale 1ns/100ps

`include "boot_macros.svh"

module boot_tb;

   //////////////////////////////
   // Constants and signals
   //////////////////////////////

   // Opcode values from the fetch rules, the rest behave as NOP
   localparam logic [3:0] OP_NOP  = 4'd0;
   localparam logic [3:0] OP_JMP  = 4'd1;
   localparam logic [3:0] OP_JMPL = 4'd2;
   localparam logic [3:0] OP_HALT = 4'd3;

   // Longest hold that a wait accepts before it gives up
   localparam int HOLD_LIMIT = 200;

   logic               clk;
   logic               reset;
   logic               fp_reset;
   logic               power_ok;
   boot_pkg::mem_req_s mem_req;
   boot_pkg::mem_rsp_s mem_rsp;
   logic               rst_hold;
   logic               halted;

   // Memory model contents and the single outstanding read
   logic [15:0] mem [0:65535];
   logic        rsp_pending;
   logic [15:0] rsp_addr;

   // Reference model, the address of the next expected strobe
   logic [15:0] model_addr;
   logic        model_long;
   logic        model_halted;

   integer      seed;
   int          fetch_count;
   int          strobe_count;
   int          check_count;
   int          mismatch_count;
   int          error_count;

   boot_top UUT (
      .clk      (clk),
      .reset    (reset),
      .fp_reset (fp_reset),
      .power_ok (power_ok),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp),
      .rst_hold (rst_hold),
      .halted   (halted)
   );

   // 40 ns period
   always #20 clk = ~clk;

   //////////////////////////////
   // Checking helpers
   //////////////////////////////

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         mismatch_count++;
         $display("FAILED %s: expected %0h, actual %0h at %0t", test_name, expected,
                  actual, $time);
      end
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("ERROR: %s at %0t", msg, $time);
   endtask

   // Random words everywhere, but no HALT unless one is planted later
   task automatic fill_memory();
      logic [15:0] word;
      for (int addr = 0; addr < 65536; addr++) begin
         word = $random(seed);
         if (word[15:12] == OP_HALT) begin
            word[15:12] = OP_NOP;
         end
         mem[addr] = word;
      end
   endtask

   // Compares one observed strobe with the model and steps the model on
   task automatic model_fetch();
      logic [15:0] word;
      check_value("fetch address", model_addr, mem_req.addr);
      word = mem[model_addr];
      if (model_long) begin
         // Address word of a JMPL, the full target
         model_long = 1'b0;
         model_addr = word;
      end else begin
         case (word[15:12])
            OP_JMP: begin
               model_addr = {model_addr[15:12], word[11:0]};
            end
            OP_JMPL: begin
               model_addr = model_addr + 16'd1;
               model_long = 1'b1;
            end
            OP_HALT: begin
               model_halted = 1'b1;
            end
            default: begin
               model_addr = model_addr + 16'd1;
            end
         endcase
      end
   endtask

   //////////////////////////////
   // Memory model and monitor
   //////////////////////////////

   always @(negedge clk) begin
      // Data for the strobe seen one cycle ago
      mem_rsp.valid     = rsp_pending;
      mem_rsp.data.addr = rsp_pending ? mem[rsp_addr] : 16'h0000;
      rsp_pending       = (mem_req.strobe === 1'b1);
      rsp_addr          = mem_req.addr;
      // Any hold sends fetching back to the reset vector
      if (rst_hold === 1'b1) begin
         model_addr   = `BOOT_RESET_VECTOR;
         model_long   = 1'b0;
         model_halted = 1'b0;
      end
      if (mem_req.strobe === 1'b1) begin
         strobe_count++;
         if (rst_hold !== 1'b0) begin
            report_error("a read strobe appeared while rst_hold was high");
         end else if (model_halted) begin
            report_error("a read strobe appeared after a HALT word");
         end else begin
            model_fetch();
            fetch_count++;
         end
      end
   end

   //////////////////////////////
   // Test steps
   //////////////////////////////

   // Called on the edge where the last source goes away
   task automatic measure_hold(input string test_name);
      int hold_cycles;
      int held_strobes;
      hold_cycles  = 0;
      held_strobes = 0;
      while (rst_hold === 1'b1 && hold_cycles < HOLD_LIMIT) begin
         hold_cycles++;
         if (mem_req.strobe !== 1'b0) begin
            held_strobes++;
         end
         @(negedge clk);
      end
      if (hold_cycles >= HOLD_LIMIT) begin
         report_error({test_name, ": rst_hold never fell after the sources cleared"});
      end else begin
         check_value({test_name, " hold cycles"}, `BOOT_HOLD_CYCLES, hold_cycles);
         check_value({test_name, " strobes during hold"}, 0, held_strobes);
         // First fetch comes in the very first cycle without the hold
         check_value({test_name, " first strobe"}, 1, mem_req.strobe);
         check_value({test_name, " first address"}, `BOOT_RESET_VECTOR, mem_req.addr);
         check_value({test_name, " halted after restart"}, 0, halted);
      end
   endtask

   task automatic wait_fetches(input string test_name, input int count);
      int target;
      int cycles;
      target = fetch_count + count;
      cycles = 0;
      while (fetch_count < target && cycles < count * 4 + 20) begin
         @(negedge clk);
         cycles++;
      end
      if (fetch_count < target) begin
         report_error({test_name, ": fetching stopped before enough reads were seen"});
      end
   endtask

   // Front panel button held for one to three cycles
   task automatic front_panel_reset(input string test_name);
      int width;
      width    = 1 + ($unsigned($random(seed)) % 3);
      fp_reset = 1'b1;
      repeat (width) begin
         @(negedge clk);
         check_value({test_name, " rst_hold raised"}, 1, rst_hold);
      end
      fp_reset = 1'b0;
      measure_hold(test_name);
   endtask

   task automatic power_dip(input string test_name);
      int low_cycles;
      low_cycles = 5 + ($unsigned($random(seed)) % 40);
      power_ok   = 1'b0;
      repeat (low_cycles) begin
         @(negedge clk);
         check_value({test_name, " rst_hold while power bad"}, 1, rst_hold);
      end
      power_ok = 1'b1;
      measure_hold(test_name);
   endtask

   task automatic wait_halt(input string test_name);
      int cycles;
      int strobes_before;
      cycles = 0;
      while (halted !== 1'b1 && cycles < 100) begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1) begin
         report_error({test_name, ": halted never rose after the HALT word"});
      end else begin
         check_value({test_name, " model at HALT"}, 1, model_halted);
         // Quiet window, the bus must stay idle the whole time
         strobes_before = strobe_count;
         repeat (100) @(negedge clk);
         check_value({test_name, " strobes after halt"}, strobes_before, strobe_count);
         check_value({test_name, " halted held"}, 1, halted);
      end
   endtask

   //////////////////////////////
   // Sequence
   //////////////////////////////

   initial begin
      int gap;
      clk            = 1'b0;
      reset          = 1'b1;
      fp_reset       = 1'b0;
      power_ok       = 1'b1;
      mem_rsp        = '0;
      rsp_pending    = 1'b0;
      rsp_addr       = 16'h0000;
      model_addr     = `BOOT_RESET_VECTOR;
      model_long     = 1'b0;
      model_halted   = 1'b0;
      fetch_count    = 0;
      strobe_count   = 0;
      check_count    = 0;
      mismatch_count = 0;
      error_count    = 0;
      seed           = 32'h23cc_9d5f;
      fill_memory();

      repeat (10) @(negedge clk);
      reset = 1'b0;
      measure_hold("reset release");

      // Long random program, model checks every strobe address
      wait_fetches("random program", 400);

      gap = $unsigned($random(seed)) % 8;
      repeat (gap) @(negedge clk);
      front_panel_reset("front panel reset");
      wait_fetches("after front panel reset", 50);

      power_dip("power dip");
      wait_fetches("after power dip", 50);

      // Plant a JMP at the vector and a HALT at its target while held
      fp_reset = 1'b1;
      @(negedge clk);
      mem[16'hfff0] = {OP_JMP, 12'h123};
      mem[16'hf123] = {OP_HALT, 12'($random(seed))};
      front_panel_reset("halt entry");
      wait_halt("halt");
      front_panel_reset("halt exit");

      $display("Checks: %0d, mismatches: %0d, other errors: %0d, fetches: %0d",
               check_count, mismatch_count, error_count, fetch_count);
      if (mismatch_count == 0 && error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== boot_top.f ====
+incdir+verilog
verilog/boot_pkg.sv
verilog/reset_hold_timer.sv
verilog/program_counter.sv
verilog/fetch_sequencer.sv
verilog/boot_top.sv
dv/boot_tb.sv

// ==== Bender.yml ====
package:
  name: boot_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/boot_pkg.sv
      - verilog/reset_hold_timer.sv
      - verilog/program_counter.sv
      - verilog/fetch_sequencer.sv
      - verilog/boot_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/boot_tb.sv
